// ==== cache_pkg.sv ====
package cache_pkg;

	// --------------------
	// Address and data widths
	// --------------------

	// Word address is tag[27:13], index[12:3], offset[2:0]
	typedef logic [27:0]  word_addr_t;
	typedef logic [14:0]  tag_t;
	typedef logic [9:0]   index_t;
	typedef logic [2:0]   offset_t;

	typedef logic [31:0]  word_t;
	typedef logic [255:0] block_t;

	// Word address with the offset dropped
	typedef logic [24:0]  block_addr_t;

	localparam int WORDS_PER_BLOCK = 8;
	localparam int WORD_BITS = 32;

	// --------------------
	// Controller states
	// --------------------

	typedef enum logic [2:0] {
		idle,
		compare_tag,
		write_back,
		allocate,
		allocate_idle,
		flush_walk
	} ctrl_state_t;

	// Power-up contents of a memory word are the word address itself
	function automatic word_t fill_word(input word_addr_t addr);
		return {4'b0000, addr};
	endfunction

endpackage

// ==== cache_way.sv ====
`timescale 1ns/1ns

module cache_way import cache_pkg::*; #(
	parameter int SET_COUNT = 1024
) (
	input  logic   clk,
	input  logic   rst_n,
	input  index_t index,
	input  tag_t   tag,
	input  logic   write_en,
	input  block_t data_write,
	input  logic   dirty_write,
	input  logic   invalidate,
	output logic   hit,
	output logic   valid,
	output logic   dirty,
	output tag_t   stored_tag,
	output block_t data_read
);

	// Per-set status bits, tags and block data
	logic [SET_COUNT-1:0] valid_bits;
	logic [SET_COUNT-1:0] dirty_bits;
	tag_t                 tag_array  [SET_COUNT];
	block_t               data_array [SET_COUNT];

	// --------------------
	// Status update
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (write_en) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= dirty_write;
		end else if (invalidate) begin
			valid_bits[index] <= 1'b0;
			dirty_bits[index] <= 1'b0;
		end
	end

	// Tag and block payload
	always_ff @(posedge clk) begin
		if (write_en) begin
			tag_array[index]  <= tag;
			data_array[index] <= data_write;
		end
	end

	// --------------------
	// Lookup
	// --------------------

	assign valid      = valid_bits[index];
	assign dirty      = dirty_bits[index];
	assign stored_tag = tag_array[index];
	assign data_read  = data_array[index];

	assign hit = valid && (stored_tag == tag);

	// Fills and hit writes never coincide with the flush walk
	a_no_write_during_invalidate: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(write_en && invalidate)
	);

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/1ns

module cache_controller import cache_pkg::*; #(
	parameter int SET_COUNT = 1024
) (
	input  logic        clk,
	input  logic        rst_n,

	// Processor side
	input  word_addr_t  cache_addr,
	input  word_t       cache_wr,
	input  logic        cache_rw,
	input  logic        cache_valid,
	input  logic        flush,
	output word_t       cache_rd,
	output logic        cache_ready,

	// Backing memory
	output block_addr_t mem_addr,
	output block_t      mem_wr,
	output logic        mem_rw,
	output logic        mem_valid,
	input  block_t      mem_rd,
	input  logic        mem_ready,

	// IO bypass
	output word_addr_t  io_addr,
	output word_t       io_wr,
	output logic        io_rw,
	output logic        io_valid,
	input  word_t       io_rd,
	input  logic        io_ready
);

	tag_t        req_tag;
	index_t      req_index;
	offset_t     req_offset;
	logic        io_sel;
	logic        req_valid;

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Way to replace next is the one not most recently hit
	logic        lru;

	index_t      flush_set;
	logic        flush_way;
	logic        flush_step;
	logic        flush_last;

	index_t      way_index;
	logic [1:0]  way_hit;
	logic [1:0]  way_valid;
	logic [1:0]  way_dirty;
	logic [1:0]  way_write_en;
	logic [1:0]  way_invalidate;
	tag_t        way_tag  [2];
	block_t      way_data [2];
	block_t      write_block;

	logic        hit;
	logic        hit_way;
	logic        sel_way;
	logic        sel_dirty;
	block_t      hit_block;
	block_t      merged_block;
	word_t       hit_word;

	logic        ctrl_ready;
	word_t       ctrl_rd;

	// --------------------
	// Request decode
	// --------------------

	assign req_tag    = cache_addr[27:13];
	assign req_index  = cache_addr[12:3];
	assign req_offset = cache_addr[2:0];

	// Bit 27 selects the IO space and bypasses the cache
	assign io_sel    = cache_addr[27];
	assign req_valid = cache_valid && !io_sel;

	// --------------------
	// Ways
	// --------------------

	assign way_index   = (state == flush_walk) ? flush_set : req_index;
	assign write_block = (state == allocate) ? mem_rd : merged_block;

	for (genvar w = 0; w < 2; w++) begin : gen_way
		assign way_write_en[w] =
			((state == compare_tag) && hit && cache_rw && way_hit[w]) ||
			((state == allocate) && mem_ready && (lru == w));
		assign way_invalidate[w] = flush_step && (flush_way == w);

		cache_way #(
			.SET_COUNT (SET_COUNT)
		) i_cache_way (
			.clk         (clk),
			.rst_n       (rst_n),
			.index       (way_index),
			.tag         (req_tag),
			.write_en    (way_write_en[w]),
			.data_write  (write_block),
			.dirty_write (state == compare_tag),
			.invalidate  (way_invalidate[w]),
			.hit         (way_hit[w]),
			.valid       (way_valid[w]),
			.dirty       (way_dirty[w]),
			.stored_tag  (way_tag[w]),
			.data_read   (way_data[w])
		);
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];

	// Victim on a miss or the slot under the flush walk
	assign sel_way   = (state == flush_walk) ? flush_way : lru;
	assign sel_dirty = way_valid[sel_way] && way_dirty[sel_way];

	// --------------------
	// Word select and merge
	// --------------------

	assign hit_block = way_data[hit_way];
	assign hit_word  = hit_block[int'(req_offset) * WORD_BITS +: WORD_BITS];

	always_comb begin
		merged_block = hit_block;
		merged_block[int'(req_offset) * WORD_BITS +: WORD_BITS] = cache_wr;
	end

	// --------------------
	// Flush walk
	// --------------------

	// Clean or empty slots advance at once while dirty ones wait for memory
	assign flush_step = (state == flush_walk) && (!sel_dirty || mem_ready);
	assign flush_last = flush_way && (flush_set == index_t'(SET_COUNT - 1));

	// --------------------
	// FSM
	// --------------------

	always_comb begin
		next_state = state;
		case (state)
			idle:          next_state = flush ? flush_walk : compare_tag;
			compare_tag: begin
				if (hit)
					next_state = idle;
				else if (sel_dirty)
					next_state = write_back;
				else
					next_state = allocate;
			end
			write_back:    if (mem_ready) next_state = allocate;
			allocate:      if (mem_ready) next_state = allocate_idle;
			allocate_idle: next_state = compare_tag;
			flush_walk:    if (flush_step && flush_last) next_state = idle;
			default:       next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= idle;
			lru       <= 1'b0;
			flush_set <= '0;
			flush_way <= 1'b0;
		end else begin
			// A dropped request abandons whatever is in progress
			state <= req_valid ? next_state : idle;

			if ((state == compare_tag) && hit)
				lru <= ~hit_way;

			if (state == idle) begin
				flush_set <= '0;
				flush_way <= 1'b0;
			end else if (flush_step) begin
				flush_way <= ~flush_way;
				if (flush_way)
					flush_set <= flush_set + 1'b1;
			end
		end
	end

	// --------------------
	// Memory request
	// --------------------

	assign mem_valid = (state == write_back) || (state == allocate) ||
		((state == flush_walk) && sel_dirty);
	assign mem_rw    = (state == write_back) || ((state == flush_walk) && sel_dirty);
	assign mem_wr    = way_data[sel_way];

	always_comb begin
		if (state == allocate)
			mem_addr = {req_tag, req_index};
		else
			mem_addr = {way_tag[sel_way], way_index};
	end

	// --------------------
	// Processor response and IO bypass
	// --------------------

	assign ctrl_ready = ((state == compare_tag) && hit) || (flush_step && flush_last);
	assign ctrl_rd    = ((state == compare_tag) && hit && !cache_rw) ? hit_word : '0;

	assign cache_rd    = io_sel ? io_rd : ctrl_rd;
	assign cache_ready = io_sel ? io_ready : ctrl_ready;

	assign io_addr  = io_sel ? cache_addr : '0;
	assign io_wr    = io_sel ? cache_wr : '0;
	assign io_rw    = io_sel && cache_rw;
	assign io_valid = io_sel && cache_valid;

	// A tag lives in at most one way of a set
	a_single_way_hit: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(way_hit[0] && way_hit[1])
	);

	// An unanswered memory request stays put while the processor waits
	a_mem_request_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_valid && !mem_ready && req_valid |=>
			mem_valid && $stable(mem_addr) && $stable(mem_rw)
	);

endmodule

// ==== block_memory.sv ====
`timescale 1ns/1ns

module block_memory import cache_pkg::*; #(
	parameter int MEM_BLOCKS  = 4096,
	parameter int MEM_LATENCY = 3
) (
	input  logic        clk,
	input  logic        rst_n,
	input  block_addr_t mem_addr,
	input  block_t      mem_wr,
	input  logic        mem_rw,
	input  logic        mem_valid,
	output block_t      mem_rd,
	output logic        mem_ready
);

	localparam int SLOT_W = $clog2(MEM_BLOCKS);
	localparam int CNT_W  = $clog2(MEM_LATENCY + 1);

	block_t             mem_array [MEM_BLOCKS];
	logic [SLOT_W-1:0]  slot;
	logic [CNT_W-1:0]   wait_cnt;

	// Addresses beyond the array wrap around
	assign slot = SLOT_W'(mem_addr % MEM_BLOCKS);

	// Every word starts out holding its own address
	initial begin
		for (int b = 0; b < MEM_BLOCKS; b++) begin
			for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
				mem_array[b][w * WORD_BITS +: WORD_BITS] =
					fill_word(word_addr_t'(b * WORDS_PER_BLOCK + w));
			end
		end
	end

	// --------------------
	// Latency counter
	// --------------------

	// Restarts on each response so back-to-back requests are timed alike
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wait_cnt <= '0;
		else if (!mem_valid || mem_ready)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	assign mem_ready = mem_valid && (wait_cnt == CNT_W'(MEM_LATENCY - 1));

	// --------------------
	// Block access
	// --------------------

	always @(posedge clk) begin
		if (mem_ready && mem_rw)
			mem_array[slot] <= mem_wr;
	end

	assign mem_rd = (mem_ready && !mem_rw) ? mem_array[slot] : '0;

	// The count never runs past the response point
	a_count_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		wait_cnt <= CNT_W'(MEM_LATENCY - 1)
	);

endmodule

// ==== cache_system.sv ====
`timescale 1ns/1ns

module cache_system import cache_pkg::*; #(
	parameter int SET_COUNT   = 1024,
	parameter int MEM_BLOCKS  = 4096,
	parameter int MEM_LATENCY = 3
) (
	input  logic       clk,
	input  logic       rst_n,

	// Processor side
	input  word_addr_t cache_addr,
	input  word_t      cache_wr,
	input  logic       cache_rw,
	input  logic       cache_valid,
	input  logic       flush,
	output word_t      cache_rd,
	output logic       cache_ready,

	// IO side
	output word_addr_t io_addr,
	output word_t      io_wr,
	output logic       io_rw,
	output logic       io_valid,
	input  word_t      io_rd,
	input  logic       io_ready
);

	// Controller to backing memory
	block_addr_t mem_addr;
	block_t      mem_wr;
	logic        mem_rw;
	logic        mem_valid;
	block_t      mem_rd;
	logic        mem_ready;

	cache_controller #(
		.SET_COUNT (SET_COUNT)
	) i_cache_controller (
		.clk         (clk),
		.rst_n       (rst_n),
		.cache_addr  (cache_addr),
		.cache_wr    (cache_wr),
		.cache_rw    (cache_rw),
		.cache_valid (cache_valid),
		.flush       (flush),
		.cache_rd    (cache_rd),
		.cache_ready (cache_ready),
		.mem_addr    (mem_addr),
		.mem_wr      (mem_wr),
		.mem_rw      (mem_rw),
		.mem_valid   (mem_valid),
		.mem_rd      (mem_rd),
		.mem_ready   (mem_ready),
		.io_addr     (io_addr),
		.io_wr       (io_wr),
		.io_rw       (io_rw),
		.io_valid    (io_valid),
		.io_rd       (io_rd),
		.io_ready    (io_ready)
	);

	block_memory #(
		.MEM_BLOCKS  (MEM_BLOCKS),
		.MEM_LATENCY (MEM_LATENCY)
	) i_block_memory (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_wr    (mem_wr),
		.mem_rw    (mem_rw),
		.mem_valid (mem_valid),
		.mem_rd    (mem_rd),
		.mem_ready (mem_ready)
	);

endmodule

// ==== tb_cache_system.sv ====
`timescale 1ns/1ns

module tb_cache_system import cache_pkg::*;;

	// Same values as the DUT defaults
	localparam int SET_COUNT   = 1024;
	localparam int MEM_LATENCY = 3;

	localparam int RANDOM_OPS      = 200;
	localparam int REQUEST_COUNT   = 40 + RANDOM_OPS;
	localparam int FLUSH_COUNT     = 1;
	localparam int WATCHDOG_CYCLES = 200 * REQUEST_COUNT + 8 +
		FLUSH_COUNT * 2 * SET_COUNT * (MEM_LATENCY + 4);

	logic        clk = 1'b0;
	logic        rst_n;
	word_addr_t  cache_addr;
	word_t       cache_wr;
	logic        cache_rw;
	logic        cache_valid;
	logic        flush;
	word_t       cache_rd;
	logic        cache_ready;
	word_addr_t  io_addr;
	word_t       io_wr;
	logic        io_rw;
	logic        io_valid;
	word_t       io_rd;
	logic        io_ready;

	// Words written so far while all others keep their power-up value
	word_t       model [word_addr_t];
	logic [15:0] lfsr_state = 16'd50;
	string       current_test;
	int          error_count;
	int          test_errors;
	int          test_count;
	int          failed_tests;

	always #50 clk = ~clk;

	cache_system i_cache_system (
		.clk         (clk),
		.rst_n       (rst_n),
		.cache_addr  (cache_addr),
		.cache_wr    (cache_wr),
		.cache_rw    (cache_rw),
		.cache_valid (cache_valid),
		.flush       (flush),
		.cache_rd    (cache_rd),
		.cache_ready (cache_ready),
		.io_addr     (io_addr),
		.io_wr       (io_wr),
		.io_rw       (io_rw),
		.io_valid    (io_valid),
		.io_rd       (io_rd),
		.io_ready    (io_ready)
	);

	// --------------------
	// Protocol checks
	// --------------------

	a_io_addr: assert property (@(posedge clk) disable iff (!rst_n)
		cache_addr[27] |-> io_addr == cache_addr)
	else begin
		$display("MISMATCH %s io_addr expected %h actual %h", current_test,
			$sampled(cache_addr), $sampled(io_addr));
		error_count++;
	end

	a_io_request: assert property (@(posedge clk) disable iff (!rst_n)
		cache_addr[27] |-> {io_wr, io_rw, io_valid} == {cache_wr, cache_rw, cache_valid})
	else begin
		$display("MISMATCH %s io request expected %h actual %h", current_test,
			$sampled({cache_wr, cache_rw, cache_valid}), $sampled({io_wr, io_rw, io_valid}));
		error_count++;
	end

	a_io_response: assert property (@(posedge clk) disable iff (!rst_n)
		cache_addr[27] |-> {cache_rd, cache_ready} == {io_rd, io_ready})
	else begin
		$display("MISMATCH %s io response expected %h actual %h", current_test,
			$sampled({io_rd, io_ready}), $sampled({cache_rd, cache_ready}));
		error_count++;
	end

	a_io_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!cache_addr[27] |-> !io_valid)
	else begin
		$display("%s: io_valid raised for a cached address", current_test);
		error_count++;
	end

	a_ready_with_request: assert property (@(posedge clk) disable iff (!rst_n)
		cache_ready |-> cache_valid)
	else begin
		$display("%s: cache_ready pulsed with no request pending", current_test);
		error_count++;
	end

	// --------------------
	// Helpers
	// --------------------

	// Taps 16, 14, 13, 11
	function automatic logic lfsr_step();
		logic feedback;
		feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], feedback};
		return feedback;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], lfsr_step()};
		return value;
	endfunction

	// Unwritten words read back as their own zero-extended address
	function automatic word_t expected_word(input word_addr_t addr);
		if (model.exists(addr))
			return model[addr];
		return {4'b0000, addr};
	endfunction

	task automatic begin_test(input string name);
		current_test = name;
		test_errors = error_count;
		test_count++;
	endtask

	task automatic end_test();
		if (error_count != test_errors)
			failed_tests++;
		$display("%s: finished with %0d errors", current_test, error_count - test_errors);
	endtask

	task automatic access(input word_addr_t addr, input logic rw, input word_t data,
			input logic do_flush, output word_t rd);
		@(posedge clk);
		cache_addr  <= addr;
		cache_wr    <= data;
		cache_rw    <= rw;
		flush       <= do_flush;
		cache_valid <= 1'b1;
		do @(negedge clk); while (!cache_ready);
		rd = cache_rd;
		@(posedge clk);
		cache_valid <= 1'b0;
		cache_rw    <= 1'b0;
		flush       <= 1'b0;
	endtask

	task automatic write_word(input word_addr_t addr, input word_t data);
		word_t unused;
		access(addr, 1'b1, data, 1'b0, unused);
		model[addr] = data;
	endtask

	task automatic read_check(input word_addr_t addr);
		word_t got;
		word_t exp;
		exp = expected_word(addr);
		access(addr, 1'b0, '0, 1'b0, got);
		assert (got == exp) else begin
			$display("MISMATCH %s addr %h expected %h actual %h", current_test, addr, exp, got);
			error_count++;
		end
	endtask

	task automatic io_access(input word_addr_t addr, input logic rw, input word_t data,
			input word_t response);
		@(posedge clk);
		cache_addr  <= addr;
		cache_wr    <= data;
		cache_rw    <= rw;
		cache_valid <= 1'b1;
		io_rd       <= response;
		io_ready    <= 1'b1;
		@(negedge clk);
		assert (cache_rd == response) else begin
			$display("MISMATCH %s cache_rd expected %h actual %h", current_test, response, cache_rd);
			error_count++;
		end
		@(posedge clk);
		cache_valid <= 1'b0;
		io_ready    <= 1'b0;
		cache_rw    <= 1'b0;
		cache_addr  <= '0;
	endtask

	// --------------------
	// Stimulus
	// --------------------

	initial begin
		word_t unused;
		word_addr_t addr;
		rst_n = 1'b0;
		cache_addr = '0;
		cache_wr = '0;
		cache_rw = 1'b0;
		cache_valid = 1'b0;
		flush = 1'b0;
		io_rd = '0;
		io_ready = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		begin_test("reset_cold_read");
		repeat (3) begin
			@(negedge clk);
			assert (!cache_ready && !io_valid) else begin
				$display("%s: cache_ready or io_valid high with no request", current_test);
				error_count++;
			end
		end
		read_check({15'd3, 10'd9, 3'd5});
		read_check({15'd0, 10'd700, 3'd0});
		end_test();

		begin_test("write_read_hit");
		write_word({15'd1, 10'd2, 3'd4}, 32'hcafe_0001);
		read_check({15'd1, 10'd2, 3'd4});
		read_check({15'd1, 10'd2, 3'd6});
		end_test();

		// Three tags into set 5 push the oldest dirty line out
		begin_test("eviction");
		for (int t = 0; t < 3; t++)
			write_word({15'(t), 10'd5, 3'd1}, 32'h5e70_0000 + t);
		for (int t = 0; t < 3; t++)
			read_check({15'(t), 10'd5, 3'd1});
		end_test();

		begin_test("io_bypass");
		for (int i = 0; i < 3; i++)
			io_access(28'h800_0000 | 28'(random_bits(12)), 1'(random_bits(1)),
				random_bits(32), random_bits(32));
		// An IO write that aliases the cached word must leave it alone
		io_access(28'h800_0000 | {15'd1, 10'd2, 3'd4}, 1'b1, 32'hdead_0004,
			random_bits(32));
		read_check({15'd1, 10'd2, 3'd4});
		end_test();

		begin_test("flush");
		for (int s = 20; s < 24; s++)
			write_word({15'(s % 4), 10'(s), 3'(s)}, 32'hf1a5_0000 + s);
		access('0, 1'b0, '0, 1'b1, unused);
		foreach (model[a])
			read_check(a);
		end_test();

		begin_test("random_traffic");
		for (int n = 0; n < RANDOM_OPS; n++) begin
			if (random_bits(1)) begin
				addr = {15'(random_bits(2)), 10'(random_bits(2)), 3'(random_bits(3))};
				write_word(addr, random_bits(32));
			end else begin
				addr = {15'(random_bits(2)), 10'(random_bits(2)), 3'(random_bits(3))};
				read_check(addr);
			end
		end
		end_test();

		$display("summary: %0d tests, %0d with errors, %0d errors in all",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired during %s, the DUT stopped answering", current_test);
		$display("test failed");
		$finish;
	end

endmodule

// ==== build.f ====
cache_pkg.sv
cache_way.sv
cache_controller.sv
block_memory.sv
cache_system.sv
tb_cache_system.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
	--top-module tb_cache_system \
	-f build.f \
	-o sim_cache_system

./obj_dir/sim_cache_system | tee "$LOG"

if grep -qx "test passed" "$LOG"; then
	echo "simulation ok"
	exit 0
fi
echo "simulation reported failure, see $LOG"
exit 1
